// File: logic/cluster_bus_pkg.sv
/*
 * port counts, widths and address map constants of the cluster bus
 * vector typedefs shared by the crossbar stages
 */

package cluster_bus_pkg;

  // port counts
  localparam int unsigned NB_INIT    = 4;
  localparam int unsigned NB_TARGET  = 3;
  localparam int unsigned NB_RSP_SRC = NB_TARGET + 1;

  // widths
  localparam int unsigned ADDR_WIDTH       = 64;
  localparam int unsigned DATA_WIDTH       = 64;
  localparam int unsigned STRB_WIDTH       = DATA_WIDTH / 8;
  localparam int unsigned ID_IN_WIDTH      = 4;
  localparam int unsigned INIT_IDX_WIDTH   = $clog2(NB_INIT);
  localparam int unsigned SRC_IDX_WIDTH    = $clog2(NB_RSP_SRC);
  localparam int unsigned ID_OUT_WIDTH     = ID_IN_WIDTH + INIT_IDX_WIDTH;
  localparam int unsigned CLUSTER_ID_WIDTH = 6;

  typedef logic [ADDR_WIDTH-1:0]       addr_t;
  typedef logic [DATA_WIDTH-1:0]       data_t;
  typedef logic [STRB_WIDTH-1:0]       strb_t;
  typedef logic [ID_IN_WIDTH-1:0]      id_in_t;
  typedef logic [ID_OUT_WIDTH-1:0]     id_out_t;
  typedef logic [CLUSTER_ID_WIDTH-1:0] cluster_id_t;
  typedef logic [NB_TARGET-1:0]        tgt_vec_t;
  typedef logic [NB_INIT-1:0]          init_vec_t;

  // address map, all offsets relative to the cluster base
  localparam addr_t       TCDM_SIZE      = 64'h0000_0000_0002_0000;
  localparam addr_t       CLUSTER_OFFSET = 64'h0000_0000_1000_0000;
  localparam int unsigned CLUSTER_SHIFT  = 22;
  localparam addr_t       PERIPH_START   = 64'h0000_0000_0020_0000;
  localparam addr_t       PERIPH_END     = 64'h0000_0000_0040_0000;
  localparam addr_t       EXT_TOP        = 64'h0000_0000_FFFF_FFFF;

  // target port indices
  localparam int unsigned TGT_TCDM   = 0;
  localparam int unsigned TGT_PERIPH = 1;
  localparam int unsigned TGT_EXT    = 2;

endpackage

// File: logic/cluster_bus_decode.sv
/*
 * address decoder of one initiator port
 * maps the request onto a target select or a decode error
 */

module cluster_bus_decode import cluster_bus_pkg::*; (
  input  cluster_id_t cluster_id_i,
  input  logic        req_valid_i,
  input  addr_t       req_addr_i,
  input  tgt_vec_t    gnt_i,
  input  logic        err_ready_i,
  output tgt_vec_t    sel_o,
  output logic        err_valid_o,
  output logic        req_ready_o
);

  addr_t base_addr;
  logic  hit_tcdm;
  logic  hit_periph;
  logic  hit_ext_lo;
  logic  hit_ext_hi;
  logic  hit_any;

  // cluster base moves with the cluster id in 4 MiB steps
  assign base_addr = CLUSTER_OFFSET + (addr_t'(cluster_id_i) << CLUSTER_SHIFT);

  // all windows have an exclusive end
  assign hit_tcdm   = (req_addr_i >= base_addr) && (req_addr_i < base_addr + TCDM_SIZE);
  assign hit_periph = (req_addr_i >= base_addr + PERIPH_START) &&
                      (req_addr_i < base_addr + PERIPH_END);
  assign hit_ext_lo = (req_addr_i < base_addr);
  assign hit_ext_hi = (req_addr_i >= base_addr + PERIPH_END) && (req_addr_i < EXT_TOP);
  assign hit_any    = hit_tcdm || hit_periph || hit_ext_lo || hit_ext_hi;

  always_comb begin
    sel_o = '0;
    if (req_valid_i) begin
      sel_o[TGT_TCDM]   = hit_tcdm;
      sel_o[TGT_PERIPH] = hit_periph;
      sel_o[TGT_EXT]    = hit_ext_lo || hit_ext_hi;
    end
  end

  // no default port, a miss goes to the local error responder
  assign err_valid_o = req_valid_i && !hit_any;

  assign req_ready_o = (|(sel_o & gnt_i)) || (err_valid_o && err_ready_i);

endmodule

// File: logic/cluster_bus_execute.sv
/*
 * target stage of the crossbar: round-robin arbiter over the initiators,
 * request register towards the target and response demux by id prefix
 */

module cluster_bus_execute import cluster_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  init_vec_t sel_i,
  input  addr_t     req_addr_i [NB_INIT],
  input  init_vec_t req_we_i,
  input  data_t     req_wdata_i [NB_INIT],
  input  strb_t     req_strb_i [NB_INIT],
  input  id_in_t    req_id_i [NB_INIT],
  output init_vec_t gnt_o,
  output logic      tgt_req_valid_o,
  output addr_t     tgt_req_addr_o,
  output logic      tgt_req_we_o,
  output data_t     tgt_req_wdata_o,
  output strb_t     tgt_req_strb_o,
  output id_out_t   tgt_req_id_o,
  input  logic      tgt_req_ready_i,
  input  logic      tgt_rsp_valid_i,
  input  data_t     tgt_rsp_rdata_i,
  input  id_out_t   tgt_rsp_id_i,
  input  logic      tgt_rsp_err_i,
  output logic      tgt_rsp_ready_o,
  output init_vec_t rsp_sel_o,
  output data_t     rsp_rdata_o,
  output id_in_t    rsp_id_o,
  output logic      rsp_err_o,
  input  init_vec_t rsp_ready_i
);

  logic [INIT_IDX_WIDTH-1:0] rr_ptr_q;
  logic [INIT_IDX_WIDTH-1:0] win_idx;
  logic [INIT_IDX_WIDTH-1:0] rsp_idx;
  logic                      win_found;
  logic                      can_load;
  logic                      req_valid_q;

  // first requester at or after the pointer wins
  always_comb begin
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int unsigned k = 0; k < NB_INIT; k++) begin
      cand = rr_ptr_q + k;
      if (cand >= NB_INIT) begin
        cand = cand - NB_INIT;
      end
      if (!win_found && sel_i[cand]) begin
        win_found = 1'b1;
        win_idx   = INIT_IDX_WIDTH'(cand);
      end
    end
  end

  // register is free when empty or handing its request over this cycle
  assign can_load = !req_valid_q || tgt_req_ready_i;
  assign gnt_o    = (can_load && win_found) ? (init_vec_t'(1) << win_idx) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q    <= '0;
      req_valid_q <= 1'b0;
    end else if (can_load) begin
      req_valid_q <= win_found;
      if (win_found) begin
        if (int'(win_idx) == NB_INIT - 1) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= win_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_load && win_found) begin
      tgt_req_addr_o  <= req_addr_i[win_idx];
      tgt_req_we_o    <= req_we_i[win_idx];
      tgt_req_wdata_o <= req_wdata_i[win_idx];
      tgt_req_strb_o  <= req_strb_i[win_idx];
      // initiator index goes above the initiator id
      tgt_req_id_o    <= {win_idx, req_id_i[win_idx]};
    end
  end

  assign tgt_req_valid_o = req_valid_q;

  // response demux
  assign rsp_idx         = tgt_rsp_id_i[ID_IN_WIDTH +: INIT_IDX_WIDTH];
  assign rsp_sel_o       = tgt_rsp_valid_i ? (init_vec_t'(1) << rsp_idx) : '0;
  assign rsp_rdata_o     = tgt_rsp_rdata_i;
  assign rsp_id_o        = tgt_rsp_id_i[ID_IN_WIDTH-1:0];
  assign rsp_err_o       = tgt_rsp_err_i;
  assign tgt_rsp_ready_o = rsp_ready_i[rsp_idx];

endmodule

// File: logic/cluster_bus_result.sv
/*
 * response stage of one initiator port: round-robin merge of the target
 * responses and the decode error source into one response register
 */

module cluster_bus_result import cluster_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  tgt_vec_t rsp_sel_i,
  input  data_t    rsp_rdata_i [NB_TARGET],
  input  id_in_t   rsp_id_i [NB_TARGET],
  input  tgt_vec_t rsp_err_i,
  input  logic     err_valid_i,
  input  id_in_t   err_id_i,
  output tgt_vec_t rsp_ready_o,
  output logic     err_ready_o,
  output logic     init_rsp_valid_o,
  output data_t    init_rsp_rdata_o,
  output id_in_t   init_rsp_id_o,
  output logic     init_rsp_err_o,
  input  logic     init_rsp_ready_i
);

  logic [NB_RSP_SRC-1:0]    src_req;
  logic [NB_RSP_SRC-1:0]    src_gnt;
  logic [SRC_IDX_WIDTH-1:0] rr_ptr_q;
  logic [SRC_IDX_WIDTH-1:0] win_idx;
  logic                     win_found;
  logic                     can_load;
  logic                     rsp_valid_q;
  data_t                    nxt_rdata;
  id_in_t                   nxt_id;
  logic                     nxt_err;

  // error source sits above the targets
  assign src_req = {err_valid_i, rsp_sel_i};

  always_comb begin
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int unsigned k = 0; k < NB_RSP_SRC; k++) begin
      cand = rr_ptr_q + k;
      if (cand >= NB_RSP_SRC) begin
        cand = cand - NB_RSP_SRC;
      end
      if (!win_found && src_req[cand]) begin
        win_found = 1'b1;
        win_idx   = SRC_IDX_WIDTH'(cand);
      end
    end
  end

  assign can_load    = !rsp_valid_q || init_rsp_ready_i;
  assign src_gnt     = (can_load && win_found) ? (NB_RSP_SRC'(1) << win_idx) : '0;
  assign rsp_ready_o = src_gnt[NB_TARGET-1:0];
  assign err_ready_o = src_gnt[NB_TARGET];

  always_comb begin
    if (int'(win_idx) == NB_TARGET) begin
      // decode error, zero data with the request id
      nxt_rdata = '0;
      nxt_id    = err_id_i;
      nxt_err   = 1'b1;
    end else begin
      nxt_rdata = rsp_rdata_i[win_idx];
      nxt_id    = rsp_id_i[win_idx];
      nxt_err   = rsp_err_i[win_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else if (can_load) begin
      rsp_valid_q <= win_found;
      if (win_found) begin
        if (int'(win_idx) == NB_RSP_SRC - 1) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= win_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_load && win_found) begin
      init_rsp_rdata_o <= nxt_rdata;
      init_rsp_id_o    <= nxt_id;
      init_rsp_err_o   <= nxt_err;
    end
  end

  assign init_rsp_valid_o = rsp_valid_q;

endmodule

// File: logic/cluster_bus_xbar.sv
/*
 * cluster bus crossbar top, four initiators onto tcdm, periph and ext
 */

module cluster_bus_xbar import cluster_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  cluster_id_t cluster_id_i,
  // initiator ports
  input  init_vec_t   init_req_valid_i,
  input  addr_t       init_req_addr_i [NB_INIT],
  input  init_vec_t   init_req_we_i,
  input  data_t       init_req_wdata_i [NB_INIT],
  input  strb_t       init_req_strb_i [NB_INIT],
  input  id_in_t      init_req_id_i [NB_INIT],
  output init_vec_t   init_req_ready_o,
  output init_vec_t   init_rsp_valid_o,
  output data_t       init_rsp_rdata_o [NB_INIT],
  output id_in_t      init_rsp_id_o [NB_INIT],
  output init_vec_t   init_rsp_err_o,
  input  init_vec_t   init_rsp_ready_i,
  // target ports
  output tgt_vec_t    tgt_req_valid_o,
  output addr_t       tgt_req_addr_o [NB_TARGET],
  output tgt_vec_t    tgt_req_we_o,
  output data_t       tgt_req_wdata_o [NB_TARGET],
  output strb_t       tgt_req_strb_o [NB_TARGET],
  output id_out_t     tgt_req_id_o [NB_TARGET],
  input  tgt_vec_t    tgt_req_ready_i,
  input  tgt_vec_t    tgt_rsp_valid_i,
  input  data_t       tgt_rsp_rdata_i [NB_TARGET],
  input  id_out_t     tgt_rsp_id_i [NB_TARGET],
  input  tgt_vec_t    tgt_rsp_err_i,
  output tgt_vec_t    tgt_rsp_ready_o
);

  // row per initiator and column per target, transposed below
  tgt_vec_t  dec_sel [NB_INIT];
  tgt_vec_t  dec_gnt [NB_INIT];
  tgt_vec_t  res_rsp_sel [NB_INIT];
  tgt_vec_t  res_rsp_ready [NB_INIT];
  init_vec_t exe_sel [NB_TARGET];
  init_vec_t exe_gnt [NB_TARGET];
  init_vec_t exe_rsp_sel [NB_TARGET];
  init_vec_t exe_rsp_ready [NB_TARGET];
  data_t     exe_rsp_rdata [NB_TARGET];
  id_in_t    exe_rsp_id [NB_TARGET];
  tgt_vec_t  exe_rsp_err;
  init_vec_t err_valid;
  init_vec_t err_ready;

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_transpose_i
    for (genvar j = 0; j < NB_TARGET; j++) begin : gen_transpose_j
      assign exe_sel[j][i]       = dec_sel[i][j];
      assign dec_gnt[i][j]       = exe_gnt[j][i];
      assign res_rsp_sel[i][j]   = exe_rsp_sel[j][i];
      assign exe_rsp_ready[j][i] = res_rsp_ready[i][j];
    end
  end

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_init
    cluster_bus_decode i_decode (
      .cluster_id_i (cluster_id_i),
      .req_valid_i  (init_req_valid_i[i]),
      .req_addr_i   (init_req_addr_i[i]),
      .gnt_i        (dec_gnt[i]),
      .err_ready_i  (err_ready[i]),
      .sel_o        (dec_sel[i]),
      .err_valid_o  (err_valid[i]),
      .req_ready_o  (init_req_ready_o[i])
    );

    cluster_bus_result i_result (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .rsp_sel_i        (res_rsp_sel[i]),
      .rsp_rdata_i      (exe_rsp_rdata),
      .rsp_id_i         (exe_rsp_id),
      .rsp_err_i        (exe_rsp_err),
      .err_valid_i      (err_valid[i]),
      .err_id_i         (init_req_id_i[i]),
      .rsp_ready_o      (res_rsp_ready[i]),
      .err_ready_o      (err_ready[i]),
      .init_rsp_valid_o (init_rsp_valid_o[i]),
      .init_rsp_rdata_o (init_rsp_rdata_o[i]),
      .init_rsp_id_o    (init_rsp_id_o[i]),
      .init_rsp_err_o   (init_rsp_err_o[i]),
      .init_rsp_ready_i (init_rsp_ready_i[i])
    );
  end

  for (genvar j = 0; j < NB_TARGET; j++) begin : gen_target
    cluster_bus_execute i_execute (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .sel_i           (exe_sel[j]),
      .req_addr_i      (init_req_addr_i),
      .req_we_i        (init_req_we_i),
      .req_wdata_i     (init_req_wdata_i),
      .req_strb_i      (init_req_strb_i),
      .req_id_i        (init_req_id_i),
      .gnt_o           (exe_gnt[j]),
      .tgt_req_valid_o (tgt_req_valid_o[j]),
      .tgt_req_addr_o  (tgt_req_addr_o[j]),
      .tgt_req_we_o    (tgt_req_we_o[j]),
      .tgt_req_wdata_o (tgt_req_wdata_o[j]),
      .tgt_req_strb_o  (tgt_req_strb_o[j]),
      .tgt_req_id_o    (tgt_req_id_o[j]),
      .tgt_req_ready_i (tgt_req_ready_i[j]),
      .tgt_rsp_valid_i (tgt_rsp_valid_i[j]),
      .tgt_rsp_rdata_i (tgt_rsp_rdata_i[j]),
      .tgt_rsp_id_i    (tgt_rsp_id_i[j]),
      .tgt_rsp_err_i   (tgt_rsp_err_i[j]),
      .tgt_rsp_ready_o (tgt_rsp_ready_o[j]),
      .rsp_sel_o       (exe_rsp_sel[j]),
      .rsp_rdata_o     (exe_rsp_rdata[j]),
      .rsp_id_o        (exe_rsp_id[j]),
      .rsp_err_o       (exe_rsp_err[j]),
      .rsp_ready_i     (exe_rsp_ready[j])
    );
  end

endmodule

// File: tb/tb_clock_gen.sv
/*
 * clock and reset generator of the testbench
 */

module tb_clock_gen #(
  parameter int unsigned PERIOD     = 20,
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // release away from the rising edge
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: tb/tb_cluster_bus_check.sv
/*
 * response checker: matches initiator responses against posted expectations,
 * watches response stability and the valid outputs after reset
 */

module tb_cluster_bus_check import cluster_bus_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input init_vec_t init_req_valid_i,
  input init_vec_t init_req_ready_i,
  input init_vec_t init_rsp_valid_i,
  input data_t     init_rsp_rdata_i [NB_INIT],
  input id_in_t    init_rsp_id_i [NB_INIT],
  input init_vec_t init_rsp_err_i,
  input init_vec_t init_rsp_ready_i,
  input tgt_vec_t  tgt_req_valid_i
);

  typedef struct packed {
    logic [INIT_IDX_WIDTH-1:0] init;
    id_in_t                    id;
    logic                      err;
    data_t                     data;
  } exp_rsp_t;

  exp_rsp_t exp_q [$];
  int       value_errors = 0;
  int       other_errors = 0;
  int       rsp_count    = 0;
  logic     req_seen     = 1'b0;
  logic     held [NB_INIT];
  data_t    held_rdata [NB_INIT];
  id_in_t   held_id [NB_INIT];
  logic     held_err [NB_INIT];

  task automatic report_mismatch(string sig, logic [63:0] exp, logic [63:0] act);
    value_errors++;
    $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
  endtask

  task automatic flag_error(string msg);
    other_errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic post_expected(int init, id_in_t id, logic err, data_t data);
    exp_rsp_t e;
    e.init = INIT_IDX_WIDTH'(init);
    e.id   = id;
    e.err  = err;
    e.data = data;
    exp_q.push_back(e);
  endtask

  task automatic match_response(int i);
    int pos;
    pos = -1;
    for (int k = 0; k < exp_q.size(); k++) begin
      if (pos < 0 && exp_q[k].init == i && exp_q[k].id == init_rsp_id_i[i]) begin
        pos = k;
      end
    end
    if (pos < 0) begin
      flag_error($sformatf("initiator %0d got a response with id 0x%0h it never issued",
                           i, init_rsp_id_i[i]));
    end else begin
      if (init_rsp_err_i[i] !== exp_q[pos].err) begin
        report_mismatch($sformatf("init_rsp_err_o[%0d]", i), exp_q[pos].err, init_rsp_err_i[i]);
      end
      if (init_rsp_rdata_i[i] !== exp_q[pos].data) begin
        report_mismatch($sformatf("init_rsp_rdata_o[%0d]", i), exp_q[pos].data,
                        init_rsp_rdata_i[i]);
      end
      exp_q.delete(pos);
    end
    rsp_count++;
  endtask

  task automatic check_drained();
    if (exp_q.size() != 0) begin
      flag_error($sformatf("%0d issued requests never got a response", exp_q.size()));
    end
  endtask

  initial begin
    for (int i = 0; i < NB_INIT; i++) begin
      held[i] = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    // nothing may come out before the first request has gone in
    if (arst_n_i && !req_seen && (tgt_req_valid_i !== '0 || init_rsp_valid_i !== '0)) begin
      flag_error("a valid output went high before any request was accepted");
    end
    if (arst_n_i && |(init_req_valid_i & init_req_ready_i)) begin
      req_seen = 1'b1;
    end
    for (int i = 0; i < NB_INIT; i++) begin
      if (held[i] && !init_rsp_valid_i[i]) begin
        flag_error($sformatf("init_rsp_valid_o[%0d] dropped before ready", i));
      end else if (held[i]) begin
        if (init_rsp_rdata_i[i] !== held_rdata[i]) begin
          report_mismatch($sformatf("init_rsp_rdata_o[%0d]", i), held_rdata[i],
                          init_rsp_rdata_i[i]);
        end
        if (init_rsp_id_i[i] !== held_id[i]) begin
          report_mismatch($sformatf("init_rsp_id_o[%0d]", i), held_id[i], init_rsp_id_i[i]);
        end
        if (init_rsp_err_i[i] !== held_err[i]) begin
          report_mismatch($sformatf("init_rsp_err_o[%0d]", i), held_err[i],
                          init_rsp_err_i[i]);
        end
      end
      held[i]       = init_rsp_valid_i[i] && !init_rsp_ready_i[i];
      held_rdata[i] = init_rsp_rdata_i[i];
      held_id[i]    = init_rsp_id_i[i];
      held_err[i]   = init_rsp_err_i[i];
      if (init_rsp_valid_i[i] && init_rsp_ready_i[i]) begin
        match_response(i);
      end
    end
  end

endmodule

// File: tb/tb_cluster_bus.sv
/*
 * testbench top of the cluster bus crossbar: stimulus per initiator,
 * target memory models, reference address map and watchdog
 */

module tb_cluster_bus import cluster_bus_pkg::*; ();

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RST_CYCLES   = 16;
  localparam int unsigned ROUNDS       = 6;
  // requests per initiator and round
  localparam int unsigned REQ_PER_INIT = 12;
  localparam int unsigned TOTAL_REQ    = ROUNDS * NB_INIT * REQ_PER_INIT;
  localparam int          NO_TARGET    = 3;
  localparam int          MEM_WORDS    = 256;
  localparam cluster_id_t CLUSTER_ID   = 6'd5;
  localparam logic [31:0] SEED         = 32'h4b88_c593;

  logic      clk;
  logic      arst_n;
  init_vec_t init_req_valid;
  addr_t     init_req_addr [NB_INIT];
  init_vec_t init_req_we;
  data_t     init_req_wdata [NB_INIT];
  strb_t     init_req_strb [NB_INIT];
  id_in_t    init_req_id [NB_INIT];
  init_vec_t init_req_ready;
  init_vec_t init_rsp_valid;
  data_t     init_rsp_rdata [NB_INIT];
  id_in_t    init_rsp_id [NB_INIT];
  init_vec_t init_rsp_err;
  init_vec_t init_rsp_ready;
  tgt_vec_t  tgt_req_valid;
  addr_t     tgt_req_addr [NB_TARGET];
  tgt_vec_t  tgt_req_we;
  data_t     tgt_req_wdata [NB_TARGET];
  strb_t     tgt_req_strb [NB_TARGET];
  id_out_t   tgt_req_id [NB_TARGET];
  tgt_vec_t  tgt_req_ready;
  tgt_vec_t  tgt_rsp_valid;
  data_t     tgt_rsp_rdata [NB_TARGET];
  id_out_t   tgt_rsp_id [NB_TARGET];
  tgt_vec_t  tgt_rsp_err;
  tgt_vec_t  tgt_rsp_ready;

  // shadow memory and the request each initiator has in flight
  data_t  shadow [MEM_WORDS];
  logic   flight_vld [NB_INIT];
  addr_t  flight_addr [NB_INIT];
  logic   flight_we [NB_INIT];
  data_t  flight_wdata [NB_INIT];
  strb_t  flight_strb [NB_INIT];
  id_in_t flight_id [NB_INIT];

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clock (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  cluster_bus_xbar dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .cluster_id_i     (CLUSTER_ID),
    .init_req_valid_i (init_req_valid),
    .init_req_addr_i  (init_req_addr),
    .init_req_we_i    (init_req_we),
    .init_req_wdata_i (init_req_wdata),
    .init_req_strb_i  (init_req_strb),
    .init_req_id_i    (init_req_id),
    .init_req_ready_o (init_req_ready),
    .init_rsp_valid_o (init_rsp_valid),
    .init_rsp_rdata_o (init_rsp_rdata),
    .init_rsp_id_o    (init_rsp_id),
    .init_rsp_err_o   (init_rsp_err),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_valid_o  (tgt_req_valid),
    .tgt_req_addr_o   (tgt_req_addr),
    .tgt_req_we_o     (tgt_req_we),
    .tgt_req_wdata_o  (tgt_req_wdata),
    .tgt_req_strb_o   (tgt_req_strb),
    .tgt_req_id_o     (tgt_req_id),
    .tgt_req_ready_i  (tgt_req_ready),
    .tgt_rsp_valid_i  (tgt_rsp_valid),
    .tgt_rsp_rdata_i  (tgt_rsp_rdata),
    .tgt_rsp_id_i     (tgt_rsp_id),
    .tgt_rsp_err_i    (tgt_rsp_err),
    .tgt_rsp_ready_o  (tgt_rsp_ready)
  );

  tb_cluster_bus_check u_check (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .init_req_valid_i (init_req_valid),
    .init_req_ready_i (init_req_ready),
    .init_rsp_valid_i (init_rsp_valid),
    .init_rsp_rdata_i (init_rsp_rdata),
    .init_rsp_id_i    (init_rsp_id),
    .init_rsp_err_i   (init_rsp_err),
    .init_rsp_ready_i (init_rsp_ready),
    .tgt_req_valid_i  (tgt_req_valid)
  );

  // windows are exclusive at their upper end
  function automatic int expected_target(addr_t addr, cluster_id_t cid);
    addr_t base;
    base = CLUSTER_OFFSET + (addr_t'(cid) << CLUSTER_SHIFT);
    if (addr < base) return TGT_EXT;
    if (addr < base + TCDM_SIZE) return TGT_TCDM;
    if (addr < base + PERIPH_START) return NO_TARGET;
    if (addr < base + PERIPH_END) return TGT_PERIPH;
    if (addr < EXT_TOP) return TGT_EXT;
    return NO_TARGET;
  endfunction

  // 512-byte test windows placed on the edges of the map
  function automatic addr_t region_addr(int kind);
    addr_t base;
    base = CLUSTER_OFFSET + (addr_t'(CLUSTER_ID) << CLUSTER_SHIFT);
    case (kind)
      0:       return base + TCDM_SIZE - 'h200;
      1:       return base + PERIPH_START;
      2:       return base - 'h200;
      3:       return base + PERIPH_END;
      default: return base + TCDM_SIZE;
    endcase
  endfunction

  function automatic int mem_index(addr_t addr);
    addr_t offs;
    for (int k = 0; k < 4; k++) begin
      offs = addr - region_addr(k);
      if (offs < 'h200) return k * 64 + int'(offs >> 3);
    end
    return -1;
  endfunction

  function automatic addr_t word_addr(int k);
    return region_addr(k / 64) + addr_t'((k % 64) * 8);
  endfunction

  function automatic data_t fill_word(addr_t addr);
    return {addr[31:0] ^ addr[63:32], ~addr[31:0]};
  endfunction

  function automatic data_t apply_strobe(data_t old_word, data_t new_word, strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  // every initiator owns one word slot per round and the slots rotate between rounds
  task automatic run_initiator(int i, int round);
    int     kind;
    int     slot;
    int     tgt;
    int     idx;
    addr_t  addr;
    logic   we;
    data_t  wdata;
    strb_t  strb;
    id_in_t id;
    data_t  exp_data;
    slot = (i + round) % NB_INIT;
    for (int n = 0; n < REQ_PER_INIT; n++) begin
      // last rounds put all initiators on tcdm
      kind = (round >= 4) ? 0 : int'($urandom % 5);
      if (kind == 4) begin
        addr = region_addr(4) + ((addr_t'($urandom) % (PERIPH_START - TCDM_SIZE)) & ~addr_t'(7));
      end else begin
        addr = region_addr(kind) + addr_t'((int'($urandom % 16) * 4 + slot) * 8);
      end
      we    = 1'($urandom % 2);
      wdata = {$urandom, $urandom};
      strb  = strb_t'($urandom);
      id    = id_in_t'($urandom);
      tgt   = expected_target(addr, CLUSTER_ID);
      idx   = mem_index(addr);
      exp_data = (tgt == NO_TARGET || we) ? '0 : shadow[idx];
      if (tgt != NO_TARGET && we) begin
        shadow[idx] = apply_strobe(shadow[idx], wdata, strb);
      end
      u_check.post_expected(i, id, tgt == NO_TARGET, exp_data);
      @(negedge clk);
      flight_vld[i]     = (tgt != NO_TARGET);
      flight_addr[i]    = addr;
      flight_we[i]      = we;
      flight_wdata[i]   = wdata;
      flight_strb[i]    = strb;
      flight_id[i]      = id;
      init_req_valid[i] = 1'b1;
      init_req_addr[i]  = addr;
      init_req_we[i]    = we;
      init_req_wdata[i] = wdata;
      init_req_strb[i]  = strb;
      init_req_id[i]    = id;
      do begin
        @(posedge clk);
      end while (!init_req_ready[i]);
      @(negedge clk);
      init_req_valid[i] = 1'b0;
      do begin
        @(posedge clk);
      end while (!(init_rsp_valid[i] && init_rsp_ready[i]));
    end
  endtask

  for (genvar j = 0; j < NB_TARGET; j++) begin : gen_target_model
    data_t   mem [MEM_WORDS];
    data_t   rdata_q [$];
    id_out_t id_q [$];
    logic    held;
    addr_t   held_addr;
    logic    held_we;
    data_t   held_wdata;
    strb_t   held_strb;
    id_out_t held_id;
    logic    rsp_taken;

    initial begin
      for (int k = 0; k < MEM_WORDS; k++) begin
        mem[k] = fill_word(word_addr(k));
      end
      tgt_req_ready[j] = 1'b0;
      tgt_rsp_valid[j] = 1'b0;
      tgt_rsp_rdata[j] = '0;
      tgt_rsp_id[j]    = '0;
      tgt_rsp_err[j]   = 1'b0;
      held             = 1'b0;
      rsp_taken        = 1'b0;
    end

    // random stalls while a response holds until it is taken
    always @(negedge clk) begin
      tgt_req_ready[j] = ($urandom % 4) != 0;
      if (!tgt_rsp_valid[j] || rsp_taken) begin
        tgt_rsp_valid[j] = 1'b0;
        if (rdata_q.size() > 0 && ($urandom % 3) != 0) begin
          tgt_rsp_valid[j] = 1'b1;
          tgt_rsp_rdata[j] = rdata_q[0];
          tgt_rsp_id[j]    = id_q[0];
        end
      end
      rsp_taken = 1'b0;
    end

    always @(posedge clk) begin : take_request
      int init;
      int idx;
      if (tgt_rsp_valid[j] && tgt_rsp_ready[j]) begin
        void'(rdata_q.pop_front());
        void'(id_q.pop_front());
        rsp_taken = 1'b1;
      end
      if (held && !tgt_req_valid[j]) begin
        u_check.flag_error($sformatf("tgt_req_valid_o[%0d] dropped before ready", j));
      end else if (held) begin
        if (tgt_req_addr[j] !== held_addr) begin
          u_check.report_mismatch($sformatf("tgt_req_addr_o[%0d]", j), held_addr,
                                  tgt_req_addr[j]);
        end
        if (tgt_req_we[j] !== held_we) begin
          u_check.report_mismatch($sformatf("tgt_req_we_o[%0d]", j), held_we, tgt_req_we[j]);
        end
        if (tgt_req_wdata[j] !== held_wdata) begin
          u_check.report_mismatch($sformatf("tgt_req_wdata_o[%0d]", j), held_wdata,
                                  tgt_req_wdata[j]);
        end
        if (tgt_req_strb[j] !== held_strb) begin
          u_check.report_mismatch($sformatf("tgt_req_strb_o[%0d]", j), held_strb,
                                  tgt_req_strb[j]);
        end
        if (tgt_req_id[j] !== held_id) begin
          u_check.report_mismatch($sformatf("tgt_req_id_o[%0d]", j), held_id, tgt_req_id[j]);
        end
      end
      held       = tgt_req_valid[j] && !tgt_req_ready[j];
      held_addr  = tgt_req_addr[j];
      held_we    = tgt_req_we[j];
      held_wdata = tgt_req_wdata[j];
      held_strb  = tgt_req_strb[j];
      held_id    = tgt_req_id[j];
      if (tgt_req_valid[j] && tgt_req_ready[j]) begin
        init = int'(tgt_req_id[j][ID_OUT_WIDTH-1 -: INIT_IDX_WIDTH]);
        if (expected_target(tgt_req_addr[j], CLUSTER_ID) != j) begin
          u_check.flag_error($sformatf("address 0x%0h reached the wrong target %0d",
                                       tgt_req_addr[j], j));
        end
        if (!flight_vld[init]) begin
          u_check.flag_error($sformatf("target %0d got id 0x%0h with no such request in flight",
                                       j, tgt_req_id[j]));
        end else begin
          if (tgt_req_addr[j] !== flight_addr[init]) begin
            u_check.report_mismatch($sformatf("tgt_req_addr_o[%0d]", j), flight_addr[init],
                                    tgt_req_addr[j]);
          end
          if (tgt_req_id[j][ID_IN_WIDTH-1:0] !== flight_id[init]) begin
            u_check.report_mismatch($sformatf("tgt_req_id_o[%0d]", j), flight_id[init],
                                    tgt_req_id[j][ID_IN_WIDTH-1:0]);
          end
          if (tgt_req_we[j] !== flight_we[init]) begin
            u_check.report_mismatch($sformatf("tgt_req_we_o[%0d]", j), flight_we[init],
                                    tgt_req_we[j]);
          end
          if (tgt_req_strb[j] !== flight_strb[init]) begin
            u_check.report_mismatch($sformatf("tgt_req_strb_o[%0d]", j), flight_strb[init],
                                    tgt_req_strb[j]);
          end
          if (tgt_req_wdata[j] !== flight_wdata[init]) begin
            u_check.report_mismatch($sformatf("tgt_req_wdata_o[%0d]", j), flight_wdata[init],
                                    tgt_req_wdata[j]);
          end
        end
        flight_vld[init] = 1'b0;
        idx = mem_index(tgt_req_addr[j]);
        if (idx < 0 || tgt_req_we[j]) begin
          if (idx >= 0) mem[idx] = apply_strobe(mem[idx], tgt_req_wdata[j], tgt_req_strb[j]);
          rdata_q.push_back('0);
        end else begin
          rdata_q.push_back(mem[idx]);
        end
        id_q.push_back(tgt_req_id[j]);
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    init_req_valid = '0;
    init_req_we    = '0;
    init_rsp_ready = '0;
    for (int i = 0; i < NB_INIT; i++) begin
      init_req_addr[i]  = '0;
      init_req_wdata[i] = '0;
      init_req_strb[i]  = '0;
      init_req_id[i]    = '0;
      flight_vld[i]     = 1'b0;
    end
    for (int k = 0; k < MEM_WORDS; k++) begin
      shadow[k] = fill_word(word_addr(k));
    end
    @(posedge arst_n);
    for (int r = 0; r < ROUNDS; r++) begin
      fork
        run_initiator(0, r);
        run_initiator(1, r);
        run_initiator(2, r);
        run_initiator(3, r);
      join
    end
    repeat (20) @(negedge clk);
    u_check.check_drained();
    $display("checked %0d responses: %0d value errors, %0d other errors",
             u_check.rsp_count, u_check.value_errors, u_check.other_errors);
    if (u_check.value_errors == 0 && u_check.other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // initiator response stalls
  always @(negedge clk) begin
    for (int i = 0; i < NB_INIT; i++) begin
      init_rsp_ready[i] = ($urandom % 4) != 0;
    end
  end

  initial begin
    #((TOTAL_REQ * 200 + RST_CYCLES) * CLK_PERIOD);
    $display("watchdog: run stalled, only %0d of %0d requests got a response",
             u_check.rsp_count, TOTAL_REQ);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: cluster_bus.f
logic/cluster_bus_pkg.sv
logic/cluster_bus_decode.sv
logic/cluster_bus_execute.sv
logic/cluster_bus_result.sv
logic/cluster_bus_xbar.sv
tb/tb_clock_gen.sv
tb/tb_cluster_bus_check.sv
tb/tb_cluster_bus.sv

// File: Bender.yml
package:
  name: cluster_bus

sources:
  - logic/cluster_bus_pkg.sv
  - logic/cluster_bus_decode.sv
  - logic/cluster_bus_execute.sv
  - logic/cluster_bus_result.sv
  - logic/cluster_bus_xbar.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_cluster_bus_check.sv
      - tb/tb_cluster_bus.sv
